/* Makefile */
VERILATOR  ?= verilator
TOP        ?= kotku_io_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/kotku_io_assert.sv */
// kotku_io_assert: bus handshake and output sanity properties bound to the I/O top level
module kotku_io_assert (
  input logic                   wb_clk_i,
  input logic                   rst_n_i,
  input kotku_pkg::wb_req_t     req_i,
  input kotku_pkg::wb_rsp_t     rsp_i,
  input kotku_pkg::word_t       led_i,
  input kotku_pkg::seg7_t [1:0] hex_i
);

  logic bus_req;

  assign bus_req = req_i.cyc & req_i.stb;

  a_ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    rsp_i.ack |-> bus_req)
    else $error("ack raised without cyc and stb");

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    rsp_i.ack |=> !rsp_i.ack)
    else $error("ack high for two cycles in a row");

  // Held request with no ack yet must see it on the next edge
  a_ack_next: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (bus_req && !rsp_i.ack) |=> rsp_i.ack)
    else $error("request not acknowledged one cycle later");

  a_out_known: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    !$isunknown({led_i, hex_i}))
    else $error("unknown bits on led_o or hex_o");

endmodule

bind kotku_io kotku_io_assert kotku_io_assert_inst (
  .wb_clk_i (wb_clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (req_i),
  .rsp_i    (rsp_o),
  .led_i    (led_o),
  .hex_i    (hex_o)
);

/* bench/kotku_io_tb.sv */
// kotku_io_tb: table-driven bus master testbench for the I/O subsystem with a tick rate check
module kotku_io_tb;

  localparam int TICK_RES    = 8;
  localparam int TICK_PHASE  = 37;
  localparam int TICK_WIN    = 256 * 3;
  localparam int TICK_EXP    = (TICK_WIN * TICK_PHASE) >> TICK_RES;   // Overflows in the window
  localparam int N_TESTS     = 25;
  localparam int ACK_LIMIT   = 4;
  localparam int CYCLE_LIMIT = 4 * N_TESTS + TICK_WIN + 50;

  // Active-low digit patterns, g in bit 6 down to a in bit 0
  localparam kotku_pkg::seg7_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  typedef struct packed {
    logic              we;
    logic              tga;       // I/O cycle when set
    logic [15:0]       addr;      // Byte address
    kotku_pkg::sel_t   sel;
    kotku_pkg::word_t  wdat;
    logic              rnd_sw;    // Switches from the random source
    logic              key;
    kotku_pkg::word_t  exp_dat;   // Read data, unused for writes
    kotku_pkg::word_t  exp_led;
    kotku_pkg::post_t  exp_post;  // Code shown on the digits afterwards
  } entry_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  kotku_pkg::wb_req_t     req;
  kotku_pkg::wb_rsp_t     rsp;
  logic [7:0]             sw;
  logic                   key;
  kotku_pkg::word_t       led;
  kotku_pkg::seg7_t [1:0] hex;
  logic                   tick;

  entry_t      tests [N_TESTS];
  string       names [N_TESTS];
  int          n_entries = 0;
  int          test_cnt  = 0;
  int          fail_cnt  = 0;
  int          cycle_cnt = 0;
  int          tick_seen = 0;
  int          tick_cnt  = 0;
  logic [31:0] rnd_state = 32'hdcef;

  always #4 clk = ~clk;

  kotku_io #(
    .TICK_RES   (TICK_RES),
    .TICK_PHASE (TICK_PHASE)
  ) kotku_io_inst (
    .wb_clk_i (clk),
    .rst_n_i  (rst_n),
    .req_i    (req),
    .rsp_o    (rsp),
    .sw_i     (sw),
    .key_i    (key),
    .led_o    (led),
    .hex_o    (hex),
    .tick_o   (tick)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Both digits for a post code, high nibble in the upper digit
  function automatic logic [13:0] digits_for(input kotku_pkg::post_t code);
    return {SEG_TABLE[code[7:4]], SEG_TABLE[code[3:0]]};
  endfunction

  task automatic add_entry(input string name, input logic we, input logic tga,
                           input logic [15:0] addr, input kotku_pkg::sel_t sel,
                           input kotku_pkg::word_t wdat, input logic rnd_sw, input logic key_v,
                           input kotku_pkg::word_t exp_dat, input kotku_pkg::word_t exp_led,
                           input kotku_pkg::post_t exp_post);
    names[n_entries] = name;
    tests[n_entries] = '{we, tga, addr, sel, wdat, rnd_sw, key_v, exp_dat, exp_led, exp_post};
    n_entries++;
  endtask

  // One bus access, then the board outputs
  task automatic run_entry(input int idx);
    entry_t           e;
    logic [7:0]       sw_v;
    kotku_pkg::word_t exp_dat;
    kotku_pkg::word_t rd_dat;
    int               waited;
    int               errs;
    e    = tests[idx];
    errs = 0;
    sw_v = 8'h00;
    if (e.rnd_sw) begin
      rnd_state = xorshift32(rnd_state);
      sw_v      = rnd_state[7:0];
    end
    exp_dat = e.rnd_sw ? {7'h00, e.key, sw_v} : e.exp_dat;   // Word 0 layout
    @(posedge clk);
    sw      <= sw_v;
    key     <= e.key;
    req.tga <= e.tga;
    req.adr <= {4'h0, e.addr[15:1]};
    req.we  <= e.we;
    req.sel <= e.sel;
    req.dat <= e.wdat;
    req.cyc <= 1'b1;
    req.stb <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!rsp.ack && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    rd_dat = rsp.dat;
    if (!rsp.ack) begin
      $display("Test %s got no ack within %0d cycles", names[idx], ACK_LIMIT);
      errs++;
    end else if (waited != 1) begin
      $display("Fail %s: ack latency expected %0d actual %0d", names[idx], 1, waited);
      errs++;
    end
    if (rsp.ack && !e.we && rd_dat !== exp_dat) begin
      $display("Fail %s: read data expected %h actual %h", names[idx], exp_dat, rd_dat);
      errs++;
    end
    @(posedge clk);
    req.cyc <= 1'b0;
    req.stb <= 1'b0;
    req.we  <= 1'b0;
    @(negedge clk);
    if (led !== e.exp_led) begin
      $display("Fail %s: led_o expected %h actual %h", names[idx], e.exp_led, led);
      errs++;
    end
    if (hex !== digits_for(e.exp_post)) begin
      $display("Fail %s: hex_o expected %h actual %h", names[idx], digits_for(e.exp_post), hex);
      errs++;
    end
    test_cnt++;
    if (errs != 0) fail_cnt++;
    $display("%-12s %s", names[idx], (errs == 0) ? "ok" : "failed");
  endtask

  // Run length guard
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Tick pulses in a fixed window after reset
  always @(negedge clk) begin
    if (rst_n && tick_seen < TICK_WIN) begin
      tick_seen++;
      if (tick) tick_cnt++;
    end
  end

  initial begin
    rst_n <= 1'b0;
    req   <= '0;
    sw    <= 8'h00;
    key   <= 1'b0;

    //        name           we    tga   addr      sel    wdat      rnd   key
    //        exp_dat   exp_led   exp_post
    add_entry("rst_post_rd", 1'b0, 1'b1, 16'h0080, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h0000, 16'h0000, 8'h00);
    add_entry("post_wr_a5",  1'b1, 1'b1, 16'h0080, 2'b01, 16'h12A5, 1'b0, 1'b0,
              16'h0000, 16'h0000, 8'hA5);
    add_entry("post_rd_a5",  1'b0, 1'b1, 16'h0080, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h00A5, 16'h0000, 8'hA5);
    add_entry("post_wr_hi",  1'b1, 1'b1, 16'h0080, 2'b10, 16'h3C00, 1'b0, 1'b0,
              16'h0000, 16'h0000, 8'hA5);
    add_entry("post_rd_hi",  1'b0, 1'b1, 16'h0080, 2'b01, 16'h0000, 1'b0, 1'b0,
              16'h00A5, 16'h0000, 8'hA5);
    add_entry("post_wr_3c",  1'b1, 1'b1, 16'h0080, 2'b11, 16'hFF3C, 1'b0, 1'b0,
              16'h0000, 16'h0000, 8'h3C);
    add_entry("post_rd_3c",  1'b0, 1'b1, 16'h0080, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h003C, 16'h0000, 8'h3C);
    add_entry("gpio_sw_k1",  1'b0, 1'b1, 16'hF100, 2'b11, 16'h0000, 1'b1, 1'b1,
              16'h0000, 16'h0000, 8'h3C);
    add_entry("gpio_sw_k0",  1'b0, 1'b1, 16'hF100, 2'b11, 16'h0000, 1'b1, 1'b0,
              16'h0000, 16'h0000, 8'h3C);
    add_entry("gpio_w0_wr",  1'b1, 1'b1, 16'hF100, 2'b11, 16'hFFFF, 1'b0, 1'b0,
              16'h0000, 16'h0000, 8'h3C);
    add_entry("gpio_sw_chk", 1'b0, 1'b1, 16'hF100, 2'b11, 16'h0000, 1'b1, 1'b1,
              16'h0000, 16'h0000, 8'h3C);
    add_entry("led_wr_11",   1'b1, 1'b1, 16'hF102, 2'b11, 16'h1234, 1'b0, 1'b0,
              16'h0000, 16'h1234, 8'h3C);
    add_entry("led_rd_11",   1'b0, 1'b1, 16'hF102, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h1234, 16'h1234, 8'h3C);
    add_entry("led_wr_01",   1'b1, 1'b1, 16'hF102, 2'b01, 16'hABCD, 1'b0, 1'b0,
              16'h0000, 16'h12CD, 8'h3C);
    add_entry("led_rd_01",   1'b0, 1'b1, 16'hF102, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h12CD, 16'h12CD, 8'h3C);
    add_entry("led_wr_10",   1'b1, 1'b1, 16'hF102, 2'b10, 16'h5A00, 1'b0, 1'b0,
              16'h0000, 16'h5ACD, 8'h3C);
    add_entry("led_rd_10",   1'b0, 1'b1, 16'hF102, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h5ACD, 16'h5ACD, 8'h3C);
    add_entry("led_wr_00",   1'b1, 1'b1, 16'hF102, 2'b00, 16'hFFFF, 1'b0, 1'b0,
              16'h0000, 16'h5ACD, 8'h3C);
    add_entry("led_rd_00",   1'b0, 1'b1, 16'hF102, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h5ACD, 16'h5ACD, 8'h3C);
    add_entry("mem_rd_80",   1'b0, 1'b0, 16'h0080, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'hFFFF, 16'h5ACD, 8'h3C);
    add_entry("mem_wr_80",   1'b1, 1'b0, 16'h0080, 2'b11, 16'h0077, 1'b0, 1'b0,
              16'h0000, 16'h5ACD, 8'h3C);
    add_entry("post_rd_mem", 1'b0, 1'b1, 16'h0080, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h003C, 16'h5ACD, 8'h3C);
    add_entry("io_rd_81",    1'b0, 1'b1, 16'h0081, 2'b10, 16'h0000, 1'b0, 1'b0,
              16'hFFFF, 16'h5ACD, 8'h3C);
    add_entry("io_wr_81",    1'b1, 1'b1, 16'h0081, 2'b10, 16'h9900, 1'b0, 1'b0,
              16'h0000, 16'h5ACD, 8'h3C);
    add_entry("post_rd_end", 1'b0, 1'b1, 16'h0080, 2'b11, 16'h0000, 1'b0, 1'b0,
              16'h003C, 16'h5ACD, 8'h3C);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // Idle outputs straight after reset
    test_cnt++;
    if (led !== 16'h0000 || hex !== digits_for(8'h00)) begin
      $display("Fail reset_idle: led/hex expected %h/%h actual %h/%h",
               16'h0000, digits_for(8'h00), led, hex);
      fail_cnt++;
    end else begin
      $display("%-12s %s", "reset_idle", "ok");
    end

    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end

    while (tick_seen < TICK_WIN) @(negedge clk);
    test_cnt++;
    if (tick_cnt != TICK_EXP) begin
      $display("Fail tick_rate: tick count expected %0d actual %0d", TICK_EXP, tick_cnt);
      fail_cnt++;
    end else begin
      $display("%-12s %s", "tick_rate", "ok");
    end

    $display("Tests run %0d, passed %0d, failed %0d", test_cnt, test_cnt - fail_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* files.f */
hw/kotku_pkg.sv
hw/io_decoder.sv
hw/post_port.sv
hw/gpio_port.sv
hw/tick_gen.sv
hw/hex_display.sv
hw/kotku_io.sv
bench/kotku_io_assert.sv
bench/kotku_io_tb.sv

/* hw/gpio_port.sv */
// gpio_port: switch and pushbutton input word plus a byte-writable LED register
module gpio_port (
  input  logic                wb_clk_i,
  input  logic                rst_n_i,

  input  logic                stb_i,
  input  kotku_pkg::wb_req_t  req_i,
  output kotku_pkg::wb_rsp_t  rsp_o,

  input  logic [7:0]          sw_i,
  input  logic                key_i,
  output kotku_pkg::word_t    led_o
);

  kotku_pkg::word_t led;
  kotku_pkg::word_t rd_dat;
  logic             ack;
  logic             start;     // First cycle of a selected request
  logic             led_sel;   // Word 1 of the slot

  assign start   = stb_i & ~ack;
  assign led_sel = req_i.adr[1];

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      ack <= 1'b0;
      led <= '0;
    end else begin
      ack <= start;
      // Word 0 is read only, writes there just get their ack
      if (start && req_i.we && led_sel) begin
        if (req_i.sel[0]) led[7:0]  <= req_i.dat[7:0];
        if (req_i.sel[1]) led[15:8] <= req_i.dat[15:8];
      end
    end
  end

  // Read data sampled with the request, valid in the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      rd_dat <= led_sel ? led : {7'h00, key_i, sw_i};
    end
  end

  assign rsp_o.dat = rd_dat;
  assign rsp_o.ack = ack;
  assign led_o     = led;

endmodule

/* hw/hex_display.sv */
// hex_display: two-digit hexadecimal seven-segment decoder, active low
module hex_display (
  input  kotku_pkg::post_t       post_i,
  output kotku_pkg::seg7_t [1:0] hex_o   // Digit 0 is the low nibble
);

  // Segment g in bit 6 down to segment a in bit 0, zero lights
  function automatic kotku_pkg::seg7_t seg_of(input logic [3:0] nib);
    kotku_pkg::seg7_t seg;
    case (nib)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;   // Lower case b
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;   // Lower case d
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // One decoder per nibble
  for (genvar d = 0; d < 2; d++) begin : g_digit
    assign hex_o[d] = seg_of(post_i[4*d +: 4]);
  end

endmodule

/* hw/io_decoder.sv */
// io_decoder: slot decode of the tagged address with response steering and a default answer
module io_decoder (
  input  logic                wb_clk_i,
  input  logic                rst_n_i,

  // Master side
  input  kotku_pkg::wb_req_t  req_i,
  output kotku_pkg::wb_rsp_t  rsp_o,

  // Slave selects
  output logic                post_stb_o,
  output logic                gpio_stb_o,

  // Slave responses
  input  kotku_pkg::wb_rsp_t  post_rsp_i,
  input  kotku_pkg::wb_rsp_t  gpio_rsp_i
);

  kotku_pkg::tadr_t tadr;
  logic             bus_req;
  logic             post_hit;
  logic             gpio_hit;
  logic             miss;
  logic             miss_ack;   // Own ack for unmapped accesses

  // Masked compare against one slot
  function automatic logic slot_hit(
    input kotku_pkg::tadr_t adr,
    input kotku_pkg::tadr_t base,
    input kotku_pkg::tadr_t mask
  );
    return (adr & mask) == (base & mask);
  endfunction

  assign tadr    = {req_i.tga, req_i.adr};
  assign bus_req = req_i.cyc & req_i.stb;

  // The post code is the even byte of its word
  // An access to the odd byte alone is I/O 0x0081, which nothing decodes
  assign post_hit = slot_hit(tadr, kotku_pkg::POST_BASE, kotku_pkg::POST_MASK) &
                    req_i.sel[0];
  assign gpio_hit = slot_hit(tadr, kotku_pkg::GPIO_BASE, kotku_pkg::GPIO_MASK);
  assign miss     = ~post_hit & ~gpio_hit;

  assign post_stb_o = bus_req & post_hit;
  assign gpio_stb_o = bus_req & gpio_hit;

  // Unmapped requests still get their single ack one edge later
  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      miss_ack <= 1'b0;
    end else begin
      miss_ack <= bus_req & miss & ~miss_ack;   // No back to back ack
    end
  end

  // Steer the selected slave back to the master
  always_comb begin
    if (post_hit) begin
      rsp_o = post_rsp_i;
    end else if (gpio_hit) begin
      rsp_o = gpio_rsp_i;
    end else begin
      rsp_o.dat = kotku_pkg::UNMAPPED_DAT;
      rsp_o.ack = miss_ack;
    end
  end

endmodule

/* hw/kotku_io.sv */
// kotku_io: I/O side of the SoC with decoder, post code port, GPIO, display and tick
module kotku_io #(
  parameter int unsigned TICK_RES   = 8,
  parameter int unsigned TICK_PHASE = 37
) (
  input  logic                   wb_clk_i,
  input  logic                   rst_n_i,

  // Bus from the master
  input  kotku_pkg::wb_req_t     req_i,
  output kotku_pkg::wb_rsp_t     rsp_o,

  // Board I/O
  input  logic [7:0]             sw_i,
  input  logic                   key_i,
  output kotku_pkg::word_t       led_o,
  output kotku_pkg::seg7_t [1:0] hex_o,

  output logic                   tick_o
);

  logic               post_stb;
  logic               gpio_stb;
  kotku_pkg::wb_rsp_t post_rsp;
  kotku_pkg::wb_rsp_t gpio_rsp;
  kotku_pkg::post_t   post_code;

  io_decoder io_decoder_inst (
    .wb_clk_i   (wb_clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .rsp_o      (rsp_o),
    .post_stb_o (post_stb),
    .gpio_stb_o (gpio_stb),
    .post_rsp_i (post_rsp),
    .gpio_rsp_i (gpio_rsp)
  );

  // I/O 0x0080
  post_port post_port_inst (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .stb_i    (post_stb),
    .req_i    (req_i),
    .rsp_o    (post_rsp),
    .post_o   (post_code)
  );

  // I/O 0xF100 - 0xF103
  gpio_port gpio_port_inst (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .stb_i    (gpio_stb),
    .req_i    (req_i),
    .rsp_o    (gpio_rsp),
    .sw_i     (sw_i),
    .key_i    (key_i),
    .led_o    (led_o)
  );

  hex_display hex_display_inst (
    .post_i (post_code),
    .hex_o  (hex_o)
  );

  tick_gen #(
    .RES   (TICK_RES),
    .PHASE (TICK_PHASE)
  ) tick_gen_inst (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .tick_o   (tick_o)   // PHASE / 2**RES per clock on average
  );

endmodule

/* hw/kotku_pkg.sv */
// kotku_pkg: shared bus types, slot map and display types for the I/O subsystem
package kotku_pkg;

  // Bus vectors
  typedef logic [15:0] word_t;   // Bus data
  typedef logic [1:0]  sel_t;    // Byte lanes, bit 0 is the even byte
  typedef logic [19:1] wadr_t;   // Word address
  typedef logic [19:0] tadr_t;   // I/O tag on top of the word address

  // Display and post code
  typedef logic [6:0]  seg7_t;   // Segments g..a, active low
  typedef logic [7:0]  post_t;

  // Master request, all fields held stable until ack
  typedef struct packed {
    logic  tga;   // Set for an I/O cycle, clear for memory
    wadr_t adr;
    logic  we;
    sel_t  sel;
    word_t dat;
    logic  cyc;
    logic  stb;
  } wb_req_t;

  // Slave response
  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_rsp_t;

  // Slot map over the tagged address {tga, adr[19:1]}
  // Bit 19 is the tag and bit n below it is byte address bit n+1
  // A mask bit of one takes part in the compare

  // Post code, I/O 0x0080 only
  localparam tadr_t POST_BASE = 20'h8_0040;
  localparam tadr_t POST_MASK = 20'hF_FFFF;

  // GPIO, I/O 0xF100 - 0xF103, upper I/O bits ignored as on the ISA bus
  localparam tadr_t GPIO_BASE = 20'h8_7880;
  localparam tadr_t GPIO_MASK = 20'h8_7FFE;

  // Floating bus reads back all ones
  localparam word_t UNMAPPED_DAT = 16'hFFFF;

endpackage

/* hw/post_port.sv */
// post_port: bus register for the power-on self-test code
module post_port (
  input  logic                wb_clk_i,
  input  logic                rst_n_i,

  input  logic                stb_i,     // cyc, stb and slot hit
  input  kotku_pkg::wb_req_t  req_i,
  output kotku_pkg::wb_rsp_t  rsp_o,

  output kotku_pkg::post_t    post_o
);

  kotku_pkg::post_t code;
  logic             ack;
  logic             wr;

  // Write lands on the edge that raises ack
  assign wr = stb_i & ~ack & req_i.we & req_i.sel[0];

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      ack  <= 1'b0;
      code <= '0;
    end else begin
      ack <= stb_i & ~ack;
      if (wr) begin
        code <= req_i.dat[7:0];   // High byte is dropped
      end
    end
  end

  assign rsp_o.dat = {8'h00, code};
  assign rsp_o.ack = ack;
  assign post_o    = code;

endmodule

/* hw/tick_gen.sv */
// tick_gen: phase accumulator giving a fractional-rate tick from the bus clock
module tick_gen #(
  parameter int unsigned RES   = 8,    // Accumulator width
  parameter int unsigned PHASE = 37    // Increment per clock
) (
  input  logic wb_clk_i,
  input  logic rst_n_i,
  output logic tick_o
);

  localparam logic [RES:0] INC = (RES + 1)'(PHASE);

  logic [RES-1:0] acc;
  logic [RES:0]   sum;

  // Carry out of this cycle's add is the tick
  assign sum = {1'b0, acc} + INC;

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      acc <= '0;
    end else begin
      acc <= sum[RES-1:0];
    end
  end

  // One cycle wide as long as PHASE stays below 2**RES
  assign tick_o = sum[RES];

endmodule
